// ==== common/mmio_pkg.sv ====
`default_nettype none

package mmio_pkg;

  // Bus word and address types
  typedef logic [31:0] mmio_word_t;   // Data word, also used for byte-lane masks
  typedef logic [13:0] mmio_addr_t;   // Byte address bits 15..2
  typedef logic [3:0]  byte_en_t;     // One bit per byte lane
  typedef logic [3:0]  page_t;        // 4 KB page, byte address bits 15..12
  typedef logic [1:0]  reg_ofs_t;     // Word offset within a page

  // Address map
  localparam int    NUM_TIMERS      = 4;               // Up to 15 fit in the page field
  localparam int    NUM_PAGES       = NUM_TIMERS + 1;  // LED/switch page plus timers
  localparam page_t PAGE_LEDSW      = 4'd0;
  localparam int    PAGE_TIMER_BASE = 1;               // Timer i sits on page i + 1

  // Timer channel registers
  localparam reg_ofs_t REG_LOAD   = 2'd0;
  localparam reg_ofs_t REG_CTRL   = 2'd1;
  localparam reg_ofs_t REG_COUNT  = 2'd2;
  localparam reg_ofs_t REG_STATUS = 2'd3;

  // LED/switch registers
  localparam reg_ofs_t REG_LED    = 2'd0;
  localparam reg_ofs_t REG_INPUTS = 2'd1;

  // Timer control bits
  localparam int CTRL_EN     = 0;  // Count down
  localparam int CTRL_AUTO   = 1;  // Reload on expiry
  localparam int CTRL_IRQ_EN = 2;  // Let expired drive the interrupt

  // Board I/O widths
  localparam int LED_R_W = 10;
  localparam int LED_G_W = 8;
  localparam int SW_W    = 10;
  localparam int BTN_W   = 4;

endpackage

`default_nettype wire

// ==== hdl/mmio_decode.sv ====
`default_nettype none

module mmio_decode (
  input  wire  mmio_pkg::mmio_addr_t                         addr,
  input  wire  mmio_pkg::byte_en_t                           wren,
  output logic [mmio_pkg::NUM_PAGES-1:0]                     page_sel,
  output mmio_pkg::mmio_word_t                               ledsw_wmask,
  output mmio_pkg::mmio_word_t [mmio_pkg::NUM_TIMERS-1:0]    timer_wmask
);

  import mmio_pkg::*;

  page_t      page;       // Page field of the word address
  mmio_word_t lane_mask;  // wren widened to byte lanes

  assign page = addr[13:10];  // Byte address bits 15..12

  // Each enable covers eight data bits
  assign lane_mask = {{8{wren[3]}}, {8{wren[2]}}, {8{wren[1]}}, {8{wren[0]}}};

  // One-hot select, pages past the last timer match nothing
  always_comb begin
    page_sel    = '0;
    page_sel[0] = (page == PAGE_LEDSW);
    for (int i = 0; i < NUM_TIMERS; i++) begin
      page_sel[i+1] = (page == page_t'(PAGE_TIMER_BASE + i));
    end
  end

  // Gate lanes per block
  // An unselected block sees no write at all
  always_comb begin
    ledsw_wmask = page_sel[0] ? lane_mask : '0;
    for (int i = 0; i < NUM_TIMERS; i++) begin
      timer_wmask[i] = page_sel[i+1] ? lane_mask : '0;  // Timer i on page i + 1
    end
  end

endmodule

`default_nettype wire

// ==== timer/timer_chan.sv ====
`default_nettype none

module timer_chan (
  input  wire  clkrst_core_clk,
  input  wire  rst_n,
  input  wire  mmio_pkg::reg_ofs_t   addr,
  input  wire  mmio_pkg::mmio_word_t data_in,
  input  wire  mmio_pkg::mmio_word_t write_mask,   // Zero unless this page is selected
  output mmio_pkg::mmio_word_t       rdata,
  output logic                       timer_irq
);

  import mmio_pkg::*;

  mmio_word_t             load_q;     // Reload value
  mmio_word_t             count_q;    // Live count
  logic [CTRL_IRQ_EN:0]   ctrl_q;     // EN, AUTO, IRQ_EN
  logic                   expired_q;  // Sticky until cleared by software

  logic                   wr_any;
  logic                   wr_load;
  logic                   wr_ctrl;
  logic                   clr_status;
  logic                   expire;
  mmio_word_t             load_merged;
  logic [CTRL_IRQ_EN:0]   ctrl_merged;

  assign wr_any     = |write_mask;
  assign wr_load    = wr_any && (addr == REG_LOAD);
  assign wr_ctrl    = wr_any && (addr == REG_CTRL);
  assign clr_status = (addr == REG_STATUS) && write_mask[0] && data_in[0];  // W1C on bit 0

  // Byte-masked merge of old and new contents
  assign load_merged = (load_q & ~write_mask) | (data_in & write_mask);
  assign ctrl_merged = (ctrl_q & ~write_mask[CTRL_IRQ_EN:0]) |
                       (data_in[CTRL_IRQ_EN:0] & write_mask[CTRL_IRQ_EN:0]);

  // Last tick of a run
  // A count of 0 never gets here, so LOAD 0 never fires
  assign expire = ctrl_q[CTRL_EN] && (count_q == 32'd1);

  always_ff @(posedge clkrst_core_clk) begin
    if (!rst_n) begin
      load_q    <= '0;
      ctrl_q    <= '0;
      count_q   <= '0;
      expired_q <= 1'b0;
    end else begin
      if (wr_load) load_q <= load_merged;

      // Bus write wins over the auto-disable
      if (wr_ctrl) begin
        ctrl_q <= ctrl_merged;
      end else if (expire && !ctrl_q[CTRL_AUTO]) begin
        ctrl_q[CTRL_EN] <= 1'b0;  // One-shot stops here
      end

      // Counter
      if (wr_load) begin
        count_q <= load_merged;  // Loading also restarts the count
      end else if (expire) begin
        count_q <= ctrl_q[CTRL_AUTO] ? load_q : '0;
      end else if (ctrl_q[CTRL_EN] && (count_q != '0)) begin
        count_q <= count_q - 32'd1;
      end

      // Expiry beats a clear in the same cycle
      if (expire) begin
        expired_q <= 1'b1;
      end else if (clr_status) begin
        expired_q <= 1'b0;
      end
    end
  end

  assign timer_irq = expired_q && ctrl_q[CTRL_IRQ_EN];

  // Register readback
  always_comb begin
    case (addr)
      REG_LOAD:   rdata = load_q;
      REG_CTRL:   rdata = mmio_word_t'(ctrl_q);     // Bits 2..0
      REG_COUNT:  rdata = count_q;
      REG_STATUS: rdata = mmio_word_t'(expired_q);  // Bit 0
      default:    rdata = '0;
    endcase
  end

endmodule

`default_nettype wire

// ==== hdl/ledsw.sv ====
`default_nettype none

module ledsw (
  input  wire  clkrst_core_clk,
  input  wire  rst_n,
  input  wire  mmio_pkg::reg_ofs_t     addr,
  input  wire  mmio_pkg::mmio_word_t   data_in,
  input  wire  mmio_pkg::mmio_word_t   write_mask,
  input  wire  [mmio_pkg::SW_W-1:0]    ext_switches,  // Asynchronous board inputs
  input  wire  [mmio_pkg::BTN_W-1:0]   ext_buttons,
  output logic [mmio_pkg::LED_R_W-1:0] ext_led_r,
  output logic [mmio_pkg::LED_G_W-1:0] ext_led_g,
  output mmio_pkg::mmio_word_t         rdata
);

  import mmio_pkg::*;

  localparam int LED_W = LED_R_W + LED_G_W;

  logic [LED_W-1:0] led_q;     // Green above red
  logic [SW_W-1:0]  sw_meta;   // First synchronizer stage
  logic [SW_W-1:0]  sw_sync;
  logic [BTN_W-1:0] btn_meta;
  logic [BTN_W-1:0] btn_sync;

  always_ff @(posedge clkrst_core_clk) begin
    if (!rst_n) begin
      led_q <= '0;
    end else if (addr == REG_LED) begin
      led_q <= (led_q & ~write_mask[LED_W-1:0]) | (data_in[LED_W-1:0] & write_mask[LED_W-1:0]);
    end
  end

  // Two flops per input, value lands two edges after a change
  always_ff @(posedge clkrst_core_clk) begin
    if (!rst_n) begin
      sw_meta  <= '0;
      sw_sync  <= '0;
      btn_meta <= '0;
      btn_sync <= '0;
    end else begin
      sw_meta  <= ext_switches;
      sw_sync  <= sw_meta;
      btn_meta <= ext_buttons;
      btn_sync <= btn_meta;
    end
  end

  assign ext_led_r = led_q[LED_R_W-1:0];
  assign ext_led_g = led_q[LED_W-1:LED_R_W];

  always_comb begin
    case (addr)
      REG_LED:    rdata = mmio_word_t'(led_q);
      REG_INPUTS: rdata = mmio_word_t'({btn_sync, sw_sync});  // Buttons above switches
      default:    rdata = '0;                                 // Unused offsets
    endcase
  end

endmodule

`default_nettype wire

// ==== hdl/mmio_readback.sv ====
`default_nettype none

module mmio_readback (
  input  wire  [mmio_pkg::NUM_PAGES-1:0]                    page_sel,     // One-hot or zero
  input  wire  mmio_pkg::mmio_word_t                        ledsw_rdata,
  input  wire  mmio_pkg::mmio_word_t [mmio_pkg::NUM_TIMERS-1:0] timer_rdata,
  input  wire  [mmio_pkg::NUM_TIMERS-1:0]                   timer_irq,
  output mmio_pkg::mmio_word_t                              data_out,
  output logic                                              irq
);

  import mmio_pkg::*;

  // AND-OR mux
  // Relies on page_sel being one-hot, an empty select gives zero
  always_comb begin
    data_out = ledsw_rdata & {32{page_sel[0]}};
    for (int i = 0; i < NUM_TIMERS; i++) begin
      data_out = data_out | (timer_rdata[i] & {32{page_sel[i+1]}});  // Timer on page i + 1
    end
  end

  // Single interrupt line, no register in the path
  assign irq = |timer_irq;

endmodule

`default_nettype wire

// ==== hdl/mmio_top.sv ====
`default_nettype none

module mmio_top (
  input  wire  clkrst_core_clk,
  input  wire  rst_n,
  input  wire  mmio_pkg::mmio_addr_t     addr,      // Word address
  input  wire  mmio_pkg::byte_en_t       wren,      // Nonzero means write this cycle
  input  wire  mmio_pkg::mmio_word_t     data_in,
  output mmio_pkg::mmio_word_t           data_out,  // Combinational read
  input  wire  [mmio_pkg::SW_W-1:0]      ext_switches,
  input  wire  [mmio_pkg::BTN_W-1:0]     ext_buttons,
  output logic [mmio_pkg::LED_R_W-1:0]   ext_led_r,
  output logic [mmio_pkg::LED_G_W-1:0]   ext_led_g,
  output logic                           irq
);

  import mmio_pkg::*;

  wire [NUM_PAGES-1:0]                page_sel;
  wire mmio_word_t                    ledsw_wmask;
  wire mmio_word_t [NUM_TIMERS-1:0]   timer_wmask;
  wire mmio_word_t                    ledsw_rdata;
  wire mmio_word_t [NUM_TIMERS-1:0]   timer_rdata;
  wire [NUM_TIMERS-1:0]               timer_irq;

  // Page decode and lane masks
  mmio_decode decode_mod (
    .addr        (addr),
    .wren        (wren),
    .page_sel    (page_sel),
    .ledsw_wmask (ledsw_wmask),
    .timer_wmask (timer_wmask)
  );

  // Page 0
  ledsw ledsw_mod (
    .clkrst_core_clk (clkrst_core_clk),
    .rst_n           (rst_n),
    .addr            (addr[1:0]),      // Byte address bits 3..2
    .data_in         (data_in),
    .write_mask      (ledsw_wmask),
    .ext_switches    (ext_switches),
    .ext_buttons     (ext_buttons),
    .ext_led_r       (ext_led_r),
    .ext_led_g       (ext_led_g),
    .rdata           (ledsw_rdata)
  );

  // One channel per timer page
  for (genvar i = 0; i < NUM_TIMERS; i++) begin : g_timer
    timer_chan timer_mod (
      .clkrst_core_clk (clkrst_core_clk),
      .rst_n           (rst_n),
      .addr            (addr[1:0]),
      .data_in         (data_in),
      .write_mask      (timer_wmask[i]),
      .rdata           (timer_rdata[i]),
      .timer_irq       (timer_irq[i])
    );
  end

  // Read mux and interrupt merge
  mmio_readback readback_mod (
    .page_sel    (page_sel),
    .ledsw_rdata (ledsw_rdata),
    .timer_rdata (timer_rdata),
    .timer_irq   (timer_irq),
    .data_out    (data_out),
    .irq         (irq)
  );

endmodule

`default_nettype wire

// ==== dv/clk_gen.sv ====
`default_nettype none

module clk_gen (
  output logic clk,
  output logic rst_n
);

  timeunit 1ns;
  timeprecision 1ps;

  initial clk = 1'b0;
  always #4 clk = ~clk;  // 8 ns period

  initial begin
    rst_n = 1'b0;
    repeat (2) @(posedge clk);  // Two cycles in reset
    @(negedge clk);
    rst_n = 1'b1;
  end

endmodule

`default_nettype wire

// ==== dv/mmio_chk.sv ====
`default_nettype none

module mmio_chk (
  input wire                                              clk,
  input wire                                              rst_n,
  input wire [mmio_pkg::NUM_PAGES-1:0]                    page_sel,
  input wire mmio_pkg::mmio_word_t                        data_out,
  input wire                                              irq,
  input wire [mmio_pkg::NUM_TIMERS-1:0]                   timer_irq,
  input wire mmio_pkg::mmio_word_t [mmio_pkg::NUM_TIMERS-1:0] timer_wmask,
  input wire mmio_pkg::reg_ofs_t                          reg_ofs,
  input wire mmio_pkg::mmio_word_t [mmio_pkg::NUM_TIMERS-1:0] count,  // Live timer counts
  input wire [mmio_pkg::NUM_TIMERS-1:0]                   en          // CTRL_EN per timer
);

  timeunit 1ns;
  timeprecision 1ps;

  import mmio_pkg::*;

  logic [NUM_TIMERS-1:0] load_wr;  // LOAD written this cycle

  always_comb begin
    for (int i = 0; i < NUM_TIMERS; i++) begin
      load_wr[i] = (|timer_wmask[i]) && (reg_ofs == REG_LOAD);
    end
  end

  a_sel_onehot: assert property (@(posedge clk) $onehot0(page_sel))
    else $error("page select not one-hot");

  a_unmapped_zero: assert property (@(posedge clk) (page_sel == '0) |-> (data_out == '0))
    else $error("unmapped read not zero");

  a_irq_merge: assert property (@(posedge clk) irq == (|timer_irq))
    else $error("irq differs from channel OR");

  a_irq_reset: assert property (@(posedge clk) !rst_n |=> !irq)
    else $error("irq high after reset");

  // A stopped channel holds its count unless software reloads it
  for (genvar i = 0; i < NUM_TIMERS; i++) begin : g_cnt
    a_count_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (!en[i] && !load_wr[i]) |=> $stable(count[i]))
      else $error("count moved while disabled");
  end

endmodule

`default_nettype wire

// ==== dv/mmio_tb.sv ====
`default_nettype none

module mmio_tb;

  timeunit 1ns;
  timeprecision 1ps;

  import mmio_pkg::*;

  logic                 clk;
  logic                 rst_n;
  mmio_addr_t           addr;
  byte_en_t             wren;
  mmio_word_t           data_in;
  mmio_word_t           data_out;
  logic [SW_W-1:0]      ext_switches;
  logic [BTN_W-1:0]     ext_buttons;
  logic [LED_R_W-1:0]   ext_led_r;
  logic [LED_G_W-1:0]   ext_led_g;
  logic                 irq;

  int                   errors;
  int                   tests;
  logic [17:0]          led_m;             // Model of LED register
  mmio_word_t           load_m [NUM_TIMERS];
  logic [2:0]           ctrl_m [NUM_TIMERS];

  clk_gen u_clk (.clk(clk), .rst_n(rst_n));

  mmio_top u_dut (
    .clkrst_core_clk (clk),
    .rst_n           (rst_n),
    .addr            (addr),
    .wren            (wren),
    .data_in         (data_in),
    .data_out        (data_out),
    .ext_switches    (ext_switches),
    .ext_buttons     (ext_buttons),
    .ext_led_r       (ext_led_r),
    .ext_led_g       (ext_led_g),
    .irq             (irq)
  );

  bind mmio_top mmio_chk u_chk (
    .clk         (clkrst_core_clk),
    .rst_n       (rst_n),
    .page_sel    (page_sel),
    .data_out    (data_out),
    .irq         (irq),
    .timer_irq   (timer_irq),
    .timer_wmask (timer_wmask),
    .reg_ofs     (addr[1:0]),
    .count       ({g_timer[3].timer_mod.count_q, g_timer[2].timer_mod.count_q,
                   g_timer[1].timer_mod.count_q, g_timer[0].timer_mod.count_q}),
    .en          ({g_timer[3].timer_mod.ctrl_q[0], g_timer[2].timer_mod.ctrl_q[0],
                   g_timer[1].timer_mod.ctrl_q[0], g_timer[0].timer_mod.ctrl_q[0]})
  );

  function automatic mmio_addr_t addr_of(input int page, input int ofs);
    return {page_t'(page), 8'h00, reg_ofs_t'(ofs)};
  endfunction

  // Old bits kept where the lane is off
  function automatic mmio_word_t merge(input mmio_word_t old, input mmio_word_t nw,
                                       input byte_en_t be);
    mmio_word_t m;
    m = {{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}};
    return (old & ~m) | (nw & m);
  endfunction

  task automatic bus_write(input mmio_addr_t a, input byte_en_t be, input mmio_word_t d);
    @(negedge clk);
    addr    = a;
    wren    = be;
    data_in = d;
    @(negedge clk);  // Write lands on the edge in between
    wren    = '0;
  endtask

  task automatic bus_read(input mmio_addr_t a, output mmio_word_t v);
    @(negedge clk);
    addr = a;
    wren = '0;
    #2 v = data_out;
  endtask

  task automatic check_word(input mmio_word_t got, input mmio_word_t exp, input string what);
    if (got !== exp) begin
      errors++;
      $display("FAIL %0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_timer(input int t, input mmio_word_t cnt, input logic expd);
    mmio_word_t v;
    bus_read(addr_of(t + 1, REG_LOAD), v);
    check_word(v, load_m[t], "timer LOAD");
    bus_read(addr_of(t + 1, REG_CTRL), v);
    check_word(v, mmio_word_t'(ctrl_m[t]), "timer CTRL");
    bus_read(addr_of(t + 1, REG_COUNT), v);
    check_word(v, cnt, "timer COUNT");
    bus_read(addr_of(t + 1, REG_STATUS), v);
    check_word(v, mmio_word_t'(expd), "timer STATUS");
  endtask

  // Back to idle with LOAD, COUNT and STATUS cleared
  task automatic timer_idle(input int t);
    bus_write(addr_of(t + 1, REG_CTRL), 4'hf, 32'h0);
    bus_write(addr_of(t + 1, REG_LOAD), 4'hf, 32'h0);
    bus_write(addr_of(t + 1, REG_STATUS), 4'h1, 32'h1);
    ctrl_m[t] = '0;
    load_m[t] = '0;
  endtask

  // Polls STATUS once per cycle, returns the edge count of the first hit
  task automatic wait_expired(input int t, input int limit, input logic irq_hi,
                              output int edges);
    mmio_word_t v;
    edges = 0;
    v     = '0;
    while (!v[0] && edges < limit) begin
      edges++;
      bus_read(addr_of(t + 1, REG_STATUS), v);
      if (irq_hi && !irq) check_word(32'(irq), 32'h1, "irq dropped while polling");
    end
    if (!v[0]) begin
      errors++;
      $display("Timeout: timer %0d did not expire within %0d cycles", t, limit);
    end
  endtask

  task automatic end_test(input string name, input int err_before);
    tests++;
    $display("test %0d %s: %0d errors", tests, name, errors - err_before);
  endtask

  initial begin
    mmio_word_t v;
    mmio_word_t d;
    byte_en_t   be;
    int         e0;
    int         n;
    int         n2;
    int         t;
    int         t2;
    int         k;
    logic [SW_W-1:0]  sw;
    logic [BTN_W-1:0] btn;

    void'($urandom(32'h9ceb));
    errors = 0;
    tests = 0;
    addr = '0;
    wren = '0;
    data_in = '0;
    ext_switches = '0;
    ext_buttons = '0;
    led_m = '0;
    for (int i = 0; i < NUM_TIMERS; i++) begin
      load_m[i] = '0;
      ctrl_m[i] = '0;
    end
    k = 0;
    while (rst_n !== 1'b1 && k < 10) begin  // Reset release from clk_gen
      @(posedge clk);
      k++;
    end
    if (rst_n !== 1'b1) begin
      errors++;
      $display("Timeout: reset was not released within %0d cycles", k);
    end

    e0 = errors;  // Reset values
    for (int p = 0; p < NUM_PAGES; p++) begin
      for (int o = 0; o < 4; o++) begin
        bus_read(addr_of(p, o), v);
        check_word(v, 32'h0, "reset value");
      end
    end
    check_word(32'(irq), 32'h0, "irq after reset");
    end_test("reset", e0);

    e0 = errors;  // Byte-masked writes
    for (int i = 0; i < 12; i++) begin
      be = byte_en_t'($urandom);
      d  = $urandom;
      bus_write(addr_of(PAGE_LEDSW, REG_LED), be, d);
      led_m = 18'(merge(32'(led_m), d, be));
      bus_read(addr_of(PAGE_LEDSW, REG_LED), v);
      check_word(v, 32'(led_m), "LED register");
      check_word(32'({ext_led_g, ext_led_r}), 32'(led_m), "LED outputs");
    end
    for (t = 0; t < NUM_TIMERS; t++) begin
      for (int i = 0; i < 4; i++) begin
        be = byte_en_t'($urandom);
        d  = $urandom;
        bus_write(addr_of(t + 1, REG_LOAD), be, d);
        load_m[t] = merge(load_m[t], d, be);
        d  = $urandom & ~32'h1;  // Keep the channel stopped
        bus_write(addr_of(t + 1, REG_CTRL), be, d);
        ctrl_m[t] = 3'(merge(32'(ctrl_m[t]), d, be));
        check_timer(t, load_m[t], 1'b0);
      end
      timer_idle(t);
    end
    end_test("register writes", e0);

    e0 = errors;  // Inputs and unmapped pages
    for (int i = 0; i < 6; i++) begin
      sw  = SW_W'($urandom);
      btn = BTN_W'($urandom);
      @(negedge clk);
      ext_switches = sw;
      ext_buttons  = btn;
      @(posedge clk);
      @(posedge clk);
      bus_read(addr_of(PAGE_LEDSW, REG_INPUTS), v);
      check_word(v, 32'({btn, sw}), "switch inputs");
    end
    bus_write(addr_of(PAGE_LEDSW, REG_INPUTS), 4'hf, $urandom);
    bus_read(addr_of(PAGE_LEDSW, REG_INPUTS), v);
    check_word(v, 32'({btn, sw}), "inputs after write");
    bus_read(addr_of(PAGE_LEDSW, REG_LED), v);
    check_word(v, 32'(led_m), "LED after inputs write");
    for (int p = NUM_PAGES; p < 16; p++) begin
      for (int o = 0; o < 4; o++) begin
        bus_write(addr_of(p, o), 4'hf, $urandom);
        bus_read(addr_of(p, o), v);
        check_word(v, 32'h0, "unmapped read");
      end
    end
    bus_read(addr_of(PAGE_LEDSW, REG_LED), v);
    check_word(v, 32'(led_m), "LED after unmapped writes");
    for (t = 0; t < NUM_TIMERS; t++) check_timer(t, 32'h0, 1'b0);
    end_test("inputs and unmapped", e0);

    e0 = errors;  // One-shot timer
    for (int r = 0; r < 3; r++) begin
      t = int'($urandom % NUM_TIMERS);
      n = 1 + int'($urandom % 40);
      bus_write(addr_of(t + 1, REG_LOAD), 4'hf, 32'(n));
      load_m[t] = 32'(n);
      bus_write(addr_of(t + 1, REG_CTRL), 4'hf, 32'h5);  // EN and IRQ_EN
      wait_expired(t, 100, 1'b0, k);
      check_word(32'(k), 32'(n), "one-shot expiry edge");
      check_word(32'(irq), 32'h1, "irq on expiry");
      ctrl_m[t] = 3'b100;  // EN cleared by hardware
      check_timer(t, 32'h0, 1'b1);
      bus_write(addr_of(t + 1, REG_STATUS), 4'h1, 32'h1);
      bus_read(addr_of(t + 1, REG_STATUS), v);
      check_word(v, 32'h0, "STATUS after clear");
      check_word(32'(irq), 32'h0, "irq after clear");
      timer_idle(t);
    end
    end_test("one-shot", e0);

    e0 = errors;  // Auto reload
    t = int'($urandom % NUM_TIMERS);
    n = 2 + int'($urandom % 10);
    bus_write(addr_of(t + 1, REG_LOAD), 4'hf, 32'(n));
    load_m[t] = 32'(n);
    bus_write(addr_of(t + 1, REG_CTRL), 4'hf, 32'h3);  // EN and AUTO
    ctrl_m[t] = 3'b011;
    for (k = 1; k <= 3 * n; k++) begin
      bus_read(addr_of(t + 1, REG_COUNT), v);
      check_word(v, 32'(n - (k % n)), "auto-reload count");
    end
    bus_read(addr_of(t + 1, REG_CTRL), v);
    check_word(v, 32'h3, "auto-reload stays enabled");
    bus_read(addr_of(t + 1, REG_STATUS), v);
    check_word(v, 32'h1, "auto-reload expired");
    check_word(32'(irq), 32'h0, "irq without IRQ_EN");
    timer_idle(t);
    end_test("auto reload", e0);

    e0 = errors;  // Two channels at once
    t  = int'($urandom % NUM_TIMERS);
    t2 = (t + 1) % NUM_TIMERS;
    n  = 5 + int'($urandom % 16);
    n2 = 30 + int'($urandom % 11);
    bus_write(addr_of(t + 1, REG_LOAD), 4'hf, 32'(n));
    bus_write(addr_of(t2 + 1, REG_LOAD), 4'hf, 32'(n2));
    bus_write(addr_of(t + 1, REG_CTRL), 4'hf, 32'h5);
    bus_write(addr_of(t2 + 1, REG_CTRL), 4'hf, 32'h5);
    wait_expired(t, 60, 1'b0, k);
    check_word(32'(irq), 32'h1, "irq from first channel");
    bus_read(addr_of(t2 + 1, REG_STATUS), v);
    check_word(v, 32'h0, "second channel still running");
    bus_read(addr_of(t2 + 1, REG_COUNT), v);
    check_word(v, 32'(n2 - n), "second channel count");  // Started two edges later
    wait_expired(t2, 60, 1'b1, k);
    check_word(32'(k), 32'(n2 - n), "second channel expiry edge");
    bus_write(addr_of(t + 1, REG_STATUS), 4'h1, 32'h1);
    check_word(32'(irq), 32'h1, "irq held by second channel");
    bus_write(addr_of(t2 + 1, REG_STATUS), 4'h1, 32'h1);
    check_word(32'(irq), 32'h0, "irq after both cleared");
    timer_idle(t);
    timer_idle(t2);
    end_test("concurrent timers", e0);

    $display("tests run: %0d, errors: %0d", tests, errors);
    if (errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

  // Guard against a stuck run
  initial begin
    #2ms;
    $display("Simulation time limit reached");
    $display("Finished with errors");
    $finish;
  end

endmodule

`default_nettype wire

// ==== filelist.f ====
common/mmio_pkg.sv
hdl/mmio_decode.sv
timer/timer_chan.sv
hdl/ledsw.sv
hdl/mmio_readback.sv
hdl/mmio_top.sv
dv/clk_gen.sv
dv/mmio_chk.sv
dv/mmio_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the MMIO fabric testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert --top-module mmio_tb -f filelist.f -o vsim

status=0
./obj_dir/vsim > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "Finished with errors" sim.log; then
  exit 1
fi
if [ "$status" -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi
exit 0
